// File: hdl/rv_pkg.sv
/*
 * Shared definitions for the RV32I pipeline core: machine widths,
 * opcodes of the supported subset, ALU and forward-select encodings.
 */
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // First fetch address after reset
    localparam word_t reset_pc = 32'h0000_0000;

    // Opcodes of the supported subset
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_system = 7'b1110011;

    // pass_b serves LUI
    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_pass_b
    } alu_op_t;

    // Source of a decode operand
    typedef enum logic [1:0] {
        fwd_none,
        fwd_ex,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    // a0 carries the exit code at EBREAK
    localparam reg_idx_t exit_reg = 5'd10;

endpackage

// File: hdl/fetch_unit.sv
/*
 * Fetch unit: PC register and instruction port requests, one at a time.
 * Responses land in IF/ID; a response still in flight at a branch
 * flush is dropped on arrival.
 */
module fetch_unit (
    input  logic          clk,
    input  logic          rst,
    input  logic          stall_fetch,
    input  logic          flush_front,
    input  rv_pkg::word_t branch_target,
    input  logic          halt,
    input  logic          ifu_rvalid,
    input  rv_pkg::word_t ifu_rdata,
    input  logic          if_id_taken,
    output logic          ifu_req,
    output rv_pkg::word_t ifu_addr,
    output logic          if_id_valid,
    output rv_pkg::word_t if_id_pc,
    output rv_pkg::word_t if_id_inst
);

    rv_pkg::word_t pc;
    logic          waiting;
    logic          discard;
    logic          issue;
    logic          take_resp;

    assign ifu_addr  = pc;
    assign take_resp = ifu_rvalid && waiting && !discard;

    // New request only when nothing is outstanding and IF/ID has room
    assign issue = !halt && !stall_fetch && !waiting &&
                   (!if_id_valid || if_id_taken);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc          <= rv_pkg::reset_pc;
            ifu_req     <= 1'b0;
            waiting     <= 1'b0;
            discard     <= 1'b0;
            if_id_valid <= 1'b0;
        end else if (flush_front) begin
            pc          <= branch_target;
            ifu_req     <= 1'b0;
            // Pending response is thrown away when it shows up
            waiting     <= waiting && !ifu_rvalid;
            discard     <= waiting && !ifu_rvalid;
            if_id_valid <= 1'b0;
        end else begin
            ifu_req <= issue;
            if (issue) begin
                waiting <= 1'b1;
            end else if (ifu_rvalid) begin
                waiting <= 1'b0;
                discard <= 1'b0;
            end
            if (take_resp) begin
                pc <= pc + 32'd4;
            end
            if_id_valid <= take_resp || (if_id_valid && !if_id_taken);
        end
    end

    // IF/ID is always empty or being taken when a response arrives
    always_ff @(posedge clk) begin
        if (take_resp) begin
            if_id_pc   <= pc;
            if_id_inst <= ifu_rdata;
        end
    end

    a_ifu_one_outstanding: assert property (
        @(posedge clk) disable iff (rst)
        ifu_req |=> !ifu_req until ifu_rvalid
    );

endmodule

// File: hdl/reg_file.sv
/*
 * Integer register file, 32 x 32 bits.
 * Two combinational read ports, one write port, x0 reads as zero.
 */
module reg_file (
    input  logic             clk,
    input  logic             rst,
    input  rv_pkg::reg_idx_t rs1_idx,
    input  rv_pkg::reg_idx_t rs2_idx,
    input  logic             wen,
    input  rv_pkg::reg_idx_t waddr,
    input  rv_pkg::word_t    wdata,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data,
    output rv_pkg::word_t    exit_value
);

    rv_pkg::word_t regs [1:31];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rs1_data   = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data   = (rs2_idx == '0) ? '0 : regs[rs2_idx];
    assign exit_value = regs[rv_pkg::exit_reg];

endmodule

// File: hdl/hazard_unit.sv
/*
 * Hazard unit: forward selects for the decode operands (EX over MEM
 * over WB), load-use and memory-busy stalls, branch flush.
 */
module hazard_unit (
    input  logic             [4:0] id_rs1,
    input  logic             [4:0] id_rs2,
    input  logic                   id_valid,
    input  logic                   ex_valid,
    input  rv_pkg::reg_idx_t       ex_rd,
    input  logic                   ex_reg_wen,
    input  logic                   ex_is_load,
    input  logic                   mem_valid,
    input  rv_pkg::reg_idx_t       mem_rd,
    input  logic                   mem_reg_wen,
    input  logic                   mem_busy,
    input  logic                   wb_valid,
    input  rv_pkg::reg_idx_t       wb_rd,
    input  logic                   wb_reg_wen,
    input  logic                   branch_taken,
    output rv_pkg::fwd_sel_t       fwd_rs1,
    output rv_pkg::fwd_sel_t       fwd_rs2,
    output logic                   stall_fetch,
    output logic                   stall_decode,
    output logic                   stall_exec,
    output logic                   flush_front
);

    logic load_use;

    // Youngest writer wins
    function automatic rv_pkg::fwd_sel_t pick(input rv_pkg::reg_idx_t src);
        if (src == '0)
            return rv_pkg::fwd_none;
        else if (ex_valid && ex_reg_wen && ex_rd == src)
            return rv_pkg::fwd_ex;
        else if (mem_valid && mem_reg_wen && mem_rd == src)
            return rv_pkg::fwd_mem;
        else if (wb_valid && wb_reg_wen && wb_rd == src)
            return rv_pkg::fwd_wb;
        else
            return rv_pkg::fwd_none;
    endfunction

    always_comb begin
        fwd_rs1 = pick(id_rs1);
        fwd_rs2 = pick(id_rs2);
    end

    // Load data is not ready until the load leaves memory
    assign load_use = id_valid && ex_valid && ex_is_load && ex_reg_wen && ex_rd != '0 &&
                      (ex_rd == id_rs1 || ex_rd == id_rs2);

    assign stall_fetch  = load_use || mem_busy;
    assign stall_decode = load_use || mem_busy;
    assign stall_exec   = mem_busy;

    // Branch leaves execute on the same edge as the flush
    assign flush_front  = branch_taken && !mem_busy;

endmodule

// File: hdl/decode_stage.sv
/*
 * Decode stage: instruction decode, immediates, operand forwarding
 * and the ID/EX register. Inserts a bubble when decode alone stalls.
 */
module decode_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             if_id_valid,
    input  rv_pkg::word_t    if_id_pc,
    input  rv_pkg::word_t    if_id_inst,
    input  rv_pkg::word_t    rs1_data,
    input  rv_pkg::word_t    rs2_data,
    input  rv_pkg::fwd_sel_t fwd_rs1,
    input  rv_pkg::fwd_sel_t fwd_rs2,
    input  rv_pkg::word_t    ex_fwd,
    input  rv_pkg::word_t    mem_fwd,
    input  rv_pkg::word_t    wb_fwd,
    input  logic             stall_decode,
    input  logic             stall_exec,
    input  logic             flush_front,
    output rv_pkg::reg_idx_t id_rs1,
    output rv_pkg::reg_idx_t id_rs2,
    output logic             id_valid,
    output logic             if_id_taken,
    output logic             ex_valid,
    output rv_pkg::word_t    ex_pc,
    output rv_pkg::word_t    ex_a,
    output rv_pkg::word_t    ex_b,
    output rv_pkg::word_t    ex_imm,
    output rv_pkg::reg_idx_t ex_rd,
    output rv_pkg::alu_op_t  ex_alu_op,
    output logic             ex_use_imm,
    output logic             ex_reg_wen,
    output logic             ex_is_load,
    output logic             ex_is_store,
    output logic             ex_is_branch,
    output logic             ex_is_ebreak
);

    rv_pkg::word_t   imm_i;
    rv_pkg::word_t   imm_s;
    rv_pkg::word_t   imm_b;
    rv_pkg::word_t   imm_u;
    rv_pkg::word_t   imm;
    rv_pkg::word_t   a_val;
    rv_pkg::word_t   b_val;
    rv_pkg::alu_op_t alu_op;
    logic            uses_rs1;
    logic            uses_rs2;
    logic            use_imm;
    logic            reg_wen;
    logic            is_load;
    logic            is_store;
    logic            is_branch;
    logic            is_ebreak;

    assign imm_i = {{20{if_id_inst[31]}}, if_id_inst[31:20]};
    assign imm_s = {{20{if_id_inst[31]}}, if_id_inst[31:25], if_id_inst[11:7]};
    assign imm_b = {{19{if_id_inst[31]}}, if_id_inst[31], if_id_inst[7],
                    if_id_inst[30:25], if_id_inst[11:8], 1'b0};
    assign imm_u = {if_id_inst[31:12], 12'b0};

    // Unknown opcodes fall through as no-ops
    always_comb begin
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        use_imm   = 1'b0;
        reg_wen   = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        is_ebreak = 1'b0;
        imm       = imm_i;
        alu_op    = rv_pkg::alu_add;
        case (if_id_inst[6:0])
            rv_pkg::op_reg: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                reg_wen  = 1'b1;
                if (if_id_inst[30]) begin
                    alu_op = rv_pkg::alu_sub;
                end
            end
            rv_pkg::op_imm: begin
                uses_rs1 = 1'b1;
                use_imm  = 1'b1;
                reg_wen  = 1'b1;
            end
            rv_pkg::op_lui: begin
                use_imm = 1'b1;
                reg_wen = 1'b1;
                imm     = imm_u;
                alu_op  = rv_pkg::alu_pass_b;
            end
            rv_pkg::op_load: begin
                uses_rs1 = 1'b1;
                use_imm  = 1'b1;
                reg_wen  = 1'b1;
                is_load  = 1'b1;
            end
            rv_pkg::op_store: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                use_imm  = 1'b1;
                is_store = 1'b1;
                imm      = imm_s;
            end
            rv_pkg::op_branch: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                is_branch = 1'b1;
                imm       = imm_b;
            end
            rv_pkg::op_system: is_ebreak = 1'b1;
            default: ;
        endcase
    end

    // Unused source fields read as x0 so they never raise a hazard
    assign id_rs1      = uses_rs1 ? if_id_inst[19:15] : '0;
    assign id_rs2      = uses_rs2 ? if_id_inst[24:20] : '0;
    assign id_valid    = if_id_valid;
    assign if_id_taken = if_id_valid && !stall_decode && !flush_front;

    function automatic rv_pkg::word_t fwd_mux(input rv_pkg::fwd_sel_t sel,
                                              input rv_pkg::word_t rf_val);
        case (sel)
            rv_pkg::fwd_ex:  return ex_fwd;
            rv_pkg::fwd_mem: return mem_fwd;
            rv_pkg::fwd_wb:  return wb_fwd;
            default:         return rf_val;
        endcase
    endfunction

    always_comb begin
        a_val = fwd_mux(fwd_rs1, rs1_data);
        b_val = fwd_mux(fwd_rs2, rs2_data);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else if (flush_front) begin
            ex_valid <= 1'b0;
        end else if (!stall_exec) begin
            ex_valid <= if_id_valid && !stall_decode;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_exec) begin
            ex_pc        <= if_id_pc;
            ex_a         <= a_val;
            ex_b         <= b_val;
            ex_imm       <= imm;
            ex_rd        <= if_id_inst[11:7];
            ex_alu_op    <= alu_op;
            ex_use_imm   <= use_imm;
            ex_reg_wen   <= reg_wen;
            ex_is_load   <= is_load;
            ex_is_store  <= is_store;
            ex_is_branch <= is_branch;
            ex_is_ebreak <= is_ebreak;
        end
    end

endmodule

// File: hdl/execute_stage.sv
/*
 * Execute stage: ALU, BEQ compare and branch target, EX/MEM register.
 * The ALU result doubles as the EX forward value.
 */
module execute_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             ex_valid,
    input  rv_pkg::word_t    ex_pc,
    input  rv_pkg::word_t    ex_a,
    input  rv_pkg::word_t    ex_b,
    input  rv_pkg::word_t    ex_imm,
    input  rv_pkg::reg_idx_t ex_rd,
    input  rv_pkg::alu_op_t  ex_alu_op,
    input  logic             ex_use_imm,
    input  logic             ex_reg_wen,
    input  logic             ex_is_load,
    input  logic             ex_is_store,
    input  logic             ex_is_branch,
    input  logic             ex_is_ebreak,
    input  logic             stall_exec,
    output rv_pkg::word_t    ex_result,
    output logic             branch_taken,
    output rv_pkg::word_t    branch_target,
    output logic             mem_valid,
    output rv_pkg::word_t    mem_result,
    output rv_pkg::word_t    mem_store_data,
    output rv_pkg::reg_idx_t mem_rd,
    output logic             mem_reg_wen,
    output logic             mem_is_load,
    output logic             mem_is_store,
    output logic             mem_is_ebreak
);

    rv_pkg::word_t op_b;

    assign op_b = ex_use_imm ? ex_imm : ex_b;

    always_comb begin
        case (ex_alu_op)
            rv_pkg::alu_sub:    ex_result = ex_a - op_b;
            rv_pkg::alu_pass_b: ex_result = op_b;
            default:            ex_result = ex_a + op_b;
        endcase
    end

    // BEQ only
    assign branch_taken  = ex_valid && ex_is_branch && (ex_a == ex_b);
    assign branch_target = ex_pc + ex_imm;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_valid <= 1'b0;
        end else if (!stall_exec) begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_exec) begin
            mem_result     <= ex_result;
            mem_store_data <= ex_b;
            mem_rd         <= ex_rd;
            mem_reg_wen    <= ex_reg_wen;
            mem_is_load    <= ex_is_load;
            mem_is_store   <= ex_is_store;
            mem_is_ebreak  <= ex_is_ebreak;
        end
    end

endmodule

// File: hdl/memory_stage.sv
/*
 * Memory stage: data port request and wait, MEM/WB register and
 * EBREAK handling. MEM/WB feeds the register file write port.
 */
module memory_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             mem_valid,
    input  rv_pkg::word_t    mem_result,
    input  rv_pkg::word_t    mem_store_data,
    input  rv_pkg::reg_idx_t mem_rd,
    input  logic             mem_reg_wen,
    input  logic             mem_is_load,
    input  logic             mem_is_store,
    input  logic             mem_is_ebreak,
    input  logic             lsu_rvalid,
    input  rv_pkg::word_t    lsu_rdata,
    input  rv_pkg::word_t    exit_value,
    output logic             mem_busy,
    output rv_pkg::word_t    mem_fwd,
    output logic             lsu_req,
    output logic             lsu_wen,
    output rv_pkg::word_t    lsu_addr,
    output rv_pkg::word_t    lsu_wdata,
    output logic             wb_valid,
    output rv_pkg::reg_idx_t wb_rd,
    output logic             wb_reg_wen,
    output rv_pkg::word_t    wb_data,
    output logic             halt,
    output logic             ebreak_flag,
    output rv_pkg::word_t    exit_code
);

    logic mem_access;
    logic req_sent;
    logic wb_is_ebreak;
    logic retire;
    logic advance;

    assign mem_access = mem_valid && (mem_is_load || mem_is_store);
    assign retire     = wb_valid && wb_is_ebreak;

    // Nothing younger than EBREAK may touch memory or commit
    assign halt       = retire || ebreak_flag;

    assign lsu_req    = mem_access && !req_sent && !halt;
    assign lsu_wen    = mem_is_store;
    assign lsu_addr   = mem_result;
    assign lsu_wdata  = mem_store_data;
    assign mem_busy   = mem_access && !lsu_rvalid;
    assign mem_fwd    = mem_is_load ? lsu_rdata : mem_result;
    assign advance    = mem_valid && !mem_busy && !halt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_sent    <= 1'b0;
            wb_valid    <= 1'b0;
            wb_reg_wen  <= 1'b0;
            ebreak_flag <= 1'b0;
            exit_code   <= '0;
        end else begin
            if (lsu_req) begin
                req_sent <= 1'b1;
            end else if (lsu_rvalid) begin
                req_sent <= 1'b0;
            end
            wb_valid   <= advance;
            wb_reg_wen <= advance && mem_reg_wen;
            // x10 already holds the last older write here
            if (retire && !ebreak_flag) begin
                ebreak_flag <= 1'b1;
                exit_code   <= exit_value;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            wb_rd        <= mem_rd;
            wb_data      <= mem_fwd;
            wb_is_ebreak <= mem_is_ebreak;
        end
    end

    a_lsu_one_outstanding: assert property (
        @(posedge clk) disable iff (rst)
        lsu_req |=> !lsu_req until lsu_rvalid
    );

endmodule

// File: hdl/rv_pipe_top.sv
/*
 * Top of the five-stage RV32I pipeline core.
 * Connects fetch, decode, execute, memory, register file and hazard unit.
 */
module rv_pipe_top (
    input  logic          clk,
    input  logic          rst,
    output logic          ifu_req,
    output rv_pkg::word_t ifu_addr,
    input  logic          ifu_rvalid,
    input  rv_pkg::word_t ifu_rdata,
    output logic          lsu_req,
    output logic          lsu_wen,
    output rv_pkg::word_t lsu_addr,
    output rv_pkg::word_t lsu_wdata,
    input  logic          lsu_rvalid,
    input  rv_pkg::word_t lsu_rdata,
    output logic          ebreak_flag,
    output rv_pkg::word_t exit_code
);

    // Hazard control
    rv_pkg::fwd_sel_t fwd_rs1;
    rv_pkg::fwd_sel_t fwd_rs2;
    logic             stall_fetch;
    logic             stall_decode;
    logic             stall_exec;
    logic             flush_front;
    logic             halt;

    // IF/ID and decode
    logic             if_id_valid;
    logic             if_id_taken;
    rv_pkg::word_t    if_id_pc;
    rv_pkg::word_t    if_id_inst;
    rv_pkg::reg_idx_t id_rs1;
    rv_pkg::reg_idx_t id_rs2;
    logic             id_valid;
    rv_pkg::word_t    rs1_data;
    rv_pkg::word_t    rs2_data;

    // ID/EX
    logic             ex_valid;
    rv_pkg::word_t    ex_pc;
    rv_pkg::word_t    ex_a;
    rv_pkg::word_t    ex_b;
    rv_pkg::word_t    ex_imm;
    rv_pkg::reg_idx_t ex_rd;
    rv_pkg::alu_op_t  ex_alu_op;
    logic             ex_use_imm;
    logic             ex_reg_wen;
    logic             ex_is_load;
    logic             ex_is_store;
    logic             ex_is_branch;
    logic             ex_is_ebreak;
    rv_pkg::word_t    ex_result;
    logic             branch_taken;
    rv_pkg::word_t    branch_target;

    // EX/MEM
    logic             mem_valid;
    rv_pkg::word_t    mem_result;
    rv_pkg::word_t    mem_store_data;
    rv_pkg::reg_idx_t mem_rd;
    logic             mem_reg_wen;
    logic             mem_is_load;
    logic             mem_is_store;
    logic             mem_is_ebreak;
    logic             mem_busy;
    rv_pkg::word_t    mem_fwd;

    // MEM/WB
    logic             wb_valid;
    rv_pkg::reg_idx_t wb_rd;
    logic             wb_reg_wen;
    rv_pkg::word_t    wb_data;
    rv_pkg::word_t    exit_value;

    fetch_unit u_fetch (.*);

    reg_file u_regs (
        .clk        (clk),
        .rst        (rst),
        .rs1_idx    (id_rs1),
        .rs2_idx    (id_rs2),
        .wen        (wb_reg_wen),
        .waddr      (wb_rd),
        .wdata      (wb_data),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .exit_value (exit_value)
    );

    hazard_unit u_hazard (.*);

    decode_stage u_decode (
        .ex_fwd (ex_result),
        .wb_fwd (wb_data),
        .*
    );

    execute_stage u_execute (.*);

    memory_stage u_memory (.*);

endmodule

// File: bench/tb_mem_model.sv
/*
 * Instruction and data memory model for the pipeline testbench.
 * Holds a fixed test program and answers each port request after
 * 1 to 4 cycles, the delay drawn from a Galois LFSR.
 */
module tb_mem_model (
    input  logic          clk,
    input  logic          rst,
    input  logic          ifu_req,
    input  rv_pkg::word_t ifu_addr,
    output logic          ifu_rvalid,
    output rv_pkg::word_t ifu_rdata,
    input  logic          lsu_req,
    input  logic          lsu_wen,
    input  rv_pkg::word_t lsu_addr,
    input  rv_pkg::word_t lsu_wdata,
    output logic          lsu_rvalid,
    output rv_pkg::word_t lsu_rdata
);

    rv_pkg::word_t imem [0:63];
    rv_pkg::word_t dmem [0:63];
    rv_pkg::word_t ifu_hold;
    rv_pkg::word_t lsu_hold;
    logic [31:0]   ifu_lfsr;
    logic [31:0]   lsu_lfsr;
    int            ifu_wait;
    int            lsu_wait;

    // x^32 + x^22 + x^2 + x + 1, right-shifting Galois form
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    // Two bits per draw, one step per bit
    task automatic draw_delay(inout logic [31:0] state, output int cycles);
        logic lo;
        logic hi;
        lo = state[0];
        state = lfsr_step(state);
        hi = state[0];
        state = lfsr_step(state);
        cycles = 1 + {hi, lo};
    endtask

    function automatic rv_pkg::word_t addi_inst(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic rv_pkg::word_t add_inst(input int rd, input int rs1, input int rs2);
        return {7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
    endfunction

    function automatic rv_pkg::word_t sub_inst(input int rd, input int rs1, input int rs2);
        return {7'b0100000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
    endfunction

    function automatic rv_pkg::word_t lui_inst(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic rv_pkg::word_t lw_inst(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic rv_pkg::word_t sw_inst(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv_pkg::word_t beq_inst(input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11],
                7'b1100011};
    endfunction

    initial begin
        ifu_rvalid = 1'b0;
        ifu_rdata  = '0;
        lsu_rvalid = 1'b0;
        lsu_rdata  = '0;
        ifu_lfsr   = 32'h05da_c4ac;
        lsu_lfsr   = 32'h05da_c4ac;
        // Unused code is ADDI x0, x0, byte address; data words carry their address
        for (int i = 0; i < 64; i++) begin
            imem[i] = addi_inst(0, 0, i * 4);
            dmem[i] = 32'hdada_0000 | (i * 4);
        end
        dmem[16] = 32'h0bad_f00d;
        // Dependent arithmetic with forwarding
        imem[0]  = addi_inst(1, 0, 5);
        imem[1]  = addi_inst(2, 1, 7);
        imem[2]  = add_inst(3, 2, 1);
        imem[3]  = sub_inst(4, 3, 2);
        imem[4]  = sw_inst(4, 0, 'h80);
        imem[5]  = lui_inst(5, 'h12345);
        imem[6]  = add_inst(6, 5, 3);
        imem[7]  = sw_inst(6, 0, 'h84);
        // Load followed at once by its use
        imem[8]  = lw_inst(7, 0, 'h40);
        imem[9]  = add_inst(8, 7, 1);
        imem[10] = sw_inst(8, 0, 'h88);
        // Taken branch over two marker stores, then a not-taken one
        imem[11] = beq_inst(1, 4, 12);
        imem[12] = sw_inst(2, 0, 'hf0);
        imem[13] = sw_inst(2, 0, 'hf0);
        imem[14] = beq_inst(1, 2, 8);
        imem[15] = sw_inst(3, 0, 'h8c);
        imem[16] = addi_inst(10, 3, 25);
        imem[17] = 32'h0010_0073;
        // Store behind EBREAK that must never reach the data port
        imem[18] = sw_inst(10, 0, 'hf4);
    end

    // Instruction port
    always begin
        @(negedge clk);
        if (!rst && ifu_req) begin
            ifu_hold = ifu_addr;
            draw_delay(ifu_lfsr, ifu_wait);
            repeat (ifu_wait) @(posedge clk);
            #1;
            ifu_rdata  = imem[ifu_hold[7:2]];
            ifu_rvalid = 1'b1;
            @(posedge clk);
            #1;
            ifu_rvalid = 1'b0;
        end
    end

    // Data port, stores land when the request is seen
    always begin
        @(negedge clk);
        if (!rst && lsu_req) begin
            lsu_hold = lsu_addr;
            if (lsu_wen) begin
                dmem[lsu_hold[7:2]] = lsu_wdata;
            end
            draw_delay(lsu_lfsr, lsu_wait);
            repeat (lsu_wait) @(posedge clk);
            #1;
            if (!lsu_wen) begin
                lsu_rdata = dmem[lsu_hold[7:2]];
            end
            lsu_rvalid = 1'b1;
            @(posedge clk);
            #1;
            lsu_rvalid = 1'b0;
        end
    end

endmodule

// File: bench/tb_rv_pipe.sv
/*
 * Testbench for the RV32I pipeline core. Runs the program held by the
 * memory model and checks stores, port handshakes and the EBREAK exit.
 */
module tb_rv_pipe;

    localparam int            clk_period      = 100;
    localparam int            reset_cycles    = 16;
    localparam int            prog_words      = 19;
    localparam int            max_delay       = 4;
    localparam int            watchdog_cycles = 40 * prog_words * max_delay;
    localparam int            store_total     = 4;
    localparam rv_pkg::word_t marker_addr     = 32'h0000_00f0;
    localparam rv_pkg::word_t first_fetch     = 32'h0000_0000;
    // x10 = 17 + 25
    localparam rv_pkg::word_t exit_expected   = 32'd42;

    logic          clk;
    logic          rst;
    logic          ifu_req;
    logic          ifu_rvalid;
    logic          lsu_req;
    logic          lsu_wen;
    logic          lsu_rvalid;
    logic          ebreak_flag;
    rv_pkg::word_t ifu_addr;
    rv_pkg::word_t ifu_rdata;
    rv_pkg::word_t lsu_addr;
    rv_pkg::word_t lsu_wdata;
    rv_pkg::word_t lsu_rdata;
    rv_pkg::word_t exit_code;

    // Expected stores in program order
    // 17 - 12 = 5, 0x12345000 + 17, 0x0badf00d + 5, x3 = 17
    string         store_test [0:3] = '{"arith_fwd", "arith_lui", "load_use", "branch_not_taken"};
    rv_pkg::word_t store_addr [0:3] = '{32'h80, 32'h84, 32'h88, 32'h8c};
    rv_pkg::word_t store_data [0:3] = '{32'd5, 32'h1234_5011, 32'h0bad_f012, 32'd17};
    int            stores_seen = 0;
    logic          ifu_pending = 1'b0;
    logic          lsu_pending = 1'b0;
    logic          fetch_seen  = 1'b0;

    rv_pipe_top dut (.*);

    tb_mem_model mem_model (.*);

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string test, input string field,
                                  input rv_pkg::word_t expected, input rv_pkg::word_t actual);
        stop_on_failure($sformatf("[FAIL] %s %s: expected 0x%08h, actual 0x%08h",
                                  test, field, expected, actual));
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    ifu_req_pulse: assert property (@(posedge clk) disable iff (rst) ifu_req |=> !ifu_req)
        else stop_on_failure("ifu_req stayed high for more than one cycle");
    lsu_req_pulse: assert property (@(posedge clk) disable iff (rst) lsu_req |=> !lsu_req)
        else stop_on_failure("lsu_req stayed high for more than one cycle");
    quiet_in_reset: assert property (@(posedge clk) rst |-> !ifu_req && !lsu_req && !ebreak_flag)
        else stop_on_failure("a request or ebreak_flag was high during reset");
    quiet_after_ebreak: assert property (
        @(posedge clk) disable iff (rst) ebreak_flag |-> !ifu_req && !lsu_req
    ) else stop_on_failure("a request was issued after EBREAK");

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            assert (!(ifu_req && ifu_pending))
                else stop_on_failure("second ifu_req issued before ifu_rvalid");
            assert (!(lsu_req && lsu_pending))
                else stop_on_failure("second lsu_req issued before lsu_rvalid");
            if (ifu_req && !fetch_seen) begin
                assert (ifu_addr == first_fetch)
                    else value_mismatch("reset_fetch", "ifu_addr", first_fetch, ifu_addr);
                fetch_seen = 1'b1;
            end
            if (ifu_req) begin
                ifu_pending = 1'b1;
            end else if (ifu_rvalid) begin
                ifu_pending = 1'b0;
            end
            if (lsu_req) begin
                lsu_pending = 1'b1;
            end else if (lsu_rvalid) begin
                lsu_pending = 1'b0;
            end
            if (lsu_req && lsu_wen) begin
                assert (lsu_addr != marker_addr)
                    else stop_on_failure("store reached the marker address past a taken branch");
                assert (stores_seen < store_total)
                    else stop_on_failure("more stores issued than the program contains");
                assert (lsu_addr == store_addr[stores_seen])
                    else value_mismatch(store_test[stores_seen], "address",
                                        store_addr[stores_seen], lsu_addr);
                assert (lsu_wdata == store_data[stores_seen])
                    else value_mismatch(store_test[stores_seen], "data",
                                        store_data[stores_seen], lsu_wdata);
                stores_seen++;
            end
        end
    end

    initial begin
        #((reset_cycles + watchdog_cycles) * clk_period);
        stop_on_failure("watchdog expired before EBREAK ended the run");
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
        wait (ebreak_flag);
        @(negedge clk);
        assert (exit_code == exit_expected)
            else value_mismatch("end_of_run", "exit_code", exit_expected, exit_code);
        // Room for a stray store if the core kept going
        repeat (20) @(posedge clk);
        if (stores_seen != store_total) begin
            stop_on_failure($sformatf("only %0d of %0d expected stores were seen",
                                      stores_seen, store_total));
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: sim.f
hdl/rv_pkg.sv
hdl/fetch_unit.sv
hdl/reg_file.sv
hdl/hazard_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/rv_pipe_top.sv
bench/tb_mem_model.sv
bench/tb_rv_pipe.sv
